// File: Makefile
VERILATOR ?= verilator
TOP ?= core386Tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/busInterfaceUnit.sv
`default_nettype none

module busInterfaceUnit (
	input wire CLOCK,
	input wire RESET,
	input wire [core386Pkg::DataWidth-1:0] Datai,
	input wire READY_n,
	input wire HOLD,
	input wire codeRequest,
	input wire [core386Pkg::WordAddrWidth-1:0] codeWordAddress,
	input wire dataRequest,
	input wire [1:0] dataKind,
	input wire [7:0] ioPort,
	input wire [core386Pkg::DataWidth-1:0] writeData,
	output logic codeDone,
	output logic [core386Pkg::DataWidth-1:0] codeData,
	output logic dataDone,
	output logic [core386Pkg::DataWidth-1:0] readData,
	output logic [3:0] BE_n,
	output logic [core386Pkg::WordAddrWidth-1:0] Address,
	output logic W_R_n,
	output logic D_C_n,
	output logic M_IO_n,
	output logic ADS_n,
	output logic [core386Pkg::DataWidth-1:0] Datao
);

	localparam logic [1:0] StateIdle = 2'd0;
	localparam logic [1:0] StateT1 = 2'd1;
	localparam logic [1:0] StateT2 = 2'd2;
	localparam logic [1:0] StateHold = 2'd3;

	logic [1:0] state;
	logic [1:0] cycleKind;
	logic cycleDone;
	logic [3:0] laneEnable;

	// the cycle ends on the edge that samples READY_n low in T2
	assign cycleDone = (state == StateT2) && !READY_n;
	assign codeDone = cycleDone && (cycleKind == core386Pkg::BusCode);
	assign dataDone = cycleDone && (cycleKind != core386Pkg::BusCode);

	// both requesters take the word straight off the bus
	assign codeData = Datai;
	assign readData = Datai;

	// single byte lane picked by the low port bits
	assign laneEnable = ~(4'b0001 << ioPort[1:0]);

	always_ff @(posedge CLOCK or posedge RESET) begin
		if (RESET) begin
			state <= StateIdle;
			cycleKind <= core386Pkg::BusCode;
			ADS_n <= 1'b1;
			BE_n <= 4'b1111;
			Address <= '0;
			W_R_n <= 1'b0;
			D_C_n <= 1'b1;
			M_IO_n <= 1'b0;
			Datao <= '0;
		end else begin
			case (state)
				StateIdle: begin
					if (HOLD) begin
						state <= StateHold;
					end else if (dataRequest) begin
						// I/O cycle wins over a pending code fetch
						state <= StateT1;
						cycleKind <= dataKind;
						ADS_n <= 1'b0;
						Address <= {{(core386Pkg::WordAddrWidth - 6){1'b0}}, ioPort[7:2]};
						BE_n <= laneEnable;
						M_IO_n <= 1'b0;
						D_C_n <= 1'b1;
						W_R_n <= (dataKind == core386Pkg::BusIoWrite);
						if (dataKind == core386Pkg::BusIoWrite) begin
							Datao <= writeData;
						end
					end else if (codeRequest) begin
						state <= StateT1;
						cycleKind <= core386Pkg::BusCode;
						ADS_n <= 1'b0;
						Address <= codeWordAddress;
						// code fetches always take the whole dword
						BE_n <= 4'b0000;
						M_IO_n <= 1'b1;
						D_C_n <= 1'b0;
						W_R_n <= 1'b0;
					end
				end
				StateT1: begin
					ADS_n <= 1'b1;
					state <= StateT2;
				end
				StateT2: begin
					if (!READY_n) begin
						state <= StateIdle;
					end
				end
				StateHold: begin
					if (!HOLD) begin
						state <= StateIdle;
					end
				end
				default: begin
					state <= StateIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/core386Pkg.sv
`default_nettype none

package core386Pkg;

	// width of the data bus and of EAX, EBX
	localparam int DataWidth = 32;

	// the Address port counts dwords, byte lanes come from BE_n
	localparam int WordAddrWidth = 30;

	// opcodes that the execution unit knows
	localparam logic [7:0] OpNop = 8'h90;
	localparam logic [7:0] OpIncEax = 8'h40;
	localparam logic [7:0] OpIncEbx = 8'h43;
	localparam logic [7:0] OpMovEaxImm = 8'hB8;
	localparam logic [7:0] OpMovEbxImm = 8'hBB;
	localparam logic [7:0] OpJmpShort = 8'hEB;
	localparam logic [7:0] OpInAl = 8'hE4;
	localparam logic [7:0] OpOutAl = 8'hE6;

	// kind of bus cycle, latched by the bus unit when a cycle starts
	localparam logic [1:0] BusCode = 2'd0;
	localparam logic [1:0] BusIoRead = 2'd1;
	localparam logic [1:0] BusIoWrite = 2'd2;

	// five bytes at the queue read pointer
	// byte 0 sits in bits 7:0, byte 4 in bits 39:32
	typedef union packed {
		// opcode and a little-endian imm32, used by the MOVs
		struct packed {
			logic [31:0] imm;
			logic [7:0] opcode;
		} immForm;
		// opcode and one operand byte: jump displacement or port number
		struct packed {
			logic [23:0] unused;
			logic [7:0] operand;
			logic [7:0] opcode;
		} byteForm;
	} instrWindow_t;

endpackage

`default_nettype wire

// File: source/core386Top.sv
`default_nettype none

module core386Top #(
	parameter int QueueDepth = 16,
	parameter logic [31:0] ResetVector = 32'h000FFFF0
) (
	input wire CLOCK,
	input wire RESET,
	input wire [core386Pkg::DataWidth-1:0] Datai,
	input wire READY_n,
	input wire HOLD,
	output logic [3:0] BE_n,
	output logic [core386Pkg::WordAddrWidth-1:0] Address,
	output logic W_R_n,
	output logic D_C_n,
	output logic M_IO_n,
	output logic ADS_n,
	output logic [core386Pkg::DataWidth-1:0] Datao
);

	// code fetch path
	logic codeRequest;
	logic [core386Pkg::WordAddrWidth-1:0] codeWordAddress;
	logic codeDone;
	logic [core386Pkg::DataWidth-1:0] codeData;

	// I/O path
	logic dataRequest;
	logic [1:0] dataKind;
	logic [7:0] ioPort;
	logic [core386Pkg::DataWidth-1:0] writeData;
	logic dataDone;
	logic [core386Pkg::DataWidth-1:0] readData;

	// queue to execution unit
	core386Pkg::instrWindow_t window;
	logic [2:0] byteCount;
	logic consume;
	logic [2:0] consumeCount;
	logic flush;
	logic [31:0] flushTarget;

	busInterfaceUnit busUnit (
		.CLOCK(CLOCK),
		.RESET(RESET),
		.Datai(Datai),
		.READY_n(READY_n),
		.HOLD(HOLD),
		.codeRequest(codeRequest),
		.codeWordAddress(codeWordAddress),
		.dataRequest(dataRequest),
		.dataKind(dataKind),
		.ioPort(ioPort),
		.writeData(writeData),
		.codeDone(codeDone),
		.codeData(codeData),
		.dataDone(dataDone),
		.readData(readData),
		.BE_n(BE_n),
		.Address(Address),
		.W_R_n(W_R_n),
		.D_C_n(D_C_n),
		.M_IO_n(M_IO_n),
		.ADS_n(ADS_n),
		.Datao(Datao)
	);

	prefetchQueue #(
		.QueueDepth(QueueDepth),
		.ResetVector(ResetVector)
	) queue (
		.CLOCK(CLOCK),
		.RESET(RESET),
		.codeDone(codeDone),
		.codeData(codeData),
		.consume(consume),
		.consumeCount(consumeCount),
		.flush(flush),
		.flushTarget(flushTarget),
		.codeRequest(codeRequest),
		.codeWordAddress(codeWordAddress),
		.window(window),
		.byteCount(byteCount)
	);

	executionUnit #(
		.ResetVector(ResetVector)
	) execUnit (
		.CLOCK(CLOCK),
		.RESET(RESET),
		.window(window),
		.byteCount(byteCount),
		.dataDone(dataDone),
		.readData(readData),
		.consume(consume),
		.consumeCount(consumeCount),
		.flush(flush),
		.flushTarget(flushTarget),
		.dataRequest(dataRequest),
		.dataKind(dataKind),
		.ioPort(ioPort),
		.writeData(writeData)
	);

endmodule

`default_nettype wire

// File: source/executionUnit.sv
`default_nettype none

module executionUnit #(
	parameter logic [31:0] ResetVector = 32'h000FFFF0
) (
	input wire CLOCK,
	input wire RESET,
	input wire core386Pkg::instrWindow_t window,
	input wire [2:0] byteCount,
	input wire dataDone,
	input wire [core386Pkg::DataWidth-1:0] readData,
	output logic consume,
	output logic [2:0] consumeCount,
	output logic flush,
	output logic [31:0] flushTarget,
	output logic dataRequest,
	output logic [1:0] dataKind,
	output logic [7:0] ioPort,
	output logic [core386Pkg::DataWidth-1:0] writeData
);

	logic [core386Pkg::DataWidth-1:0] eax;
	logic [core386Pkg::DataWidth-1:0] ebx;
	// address of the opcode at the head of the queue
	logic [31:0] instrPointer;
	logic [7:0] opcode;
	logic [2:0] instrLength;
	logic isIo;
	logic isJump;
	logic haveBytes;
	logic retire;

	assign opcode = window.byteForm.opcode;
	assign ioPort = window.byteForm.operand;
	assign writeData = eax;

	// short jump is relative to the byte after its displacement
	assign flushTarget = instrPointer + 32'd2
		+ {{24{window.byteForm.operand[7]}}, window.byteForm.operand};

	always_comb begin
		instrLength = 3'd1;
		isIo = 1'b0;
		isJump = 1'b0;
		dataKind = core386Pkg::BusIoRead;
		case (opcode)
			core386Pkg::OpNop, core386Pkg::OpIncEax, core386Pkg::OpIncEbx: begin
				instrLength = 3'd1;
			end
			core386Pkg::OpMovEaxImm, core386Pkg::OpMovEbxImm: begin
				instrLength = 3'd5;
			end
			core386Pkg::OpJmpShort: begin
				instrLength = 3'd2;
				isJump = 1'b1;
			end
			core386Pkg::OpInAl: begin
				instrLength = 3'd2;
				isIo = 1'b1;
			end
			core386Pkg::OpOutAl: begin
				instrLength = 3'd2;
				isIo = 1'b1;
				dataKind = core386Pkg::BusIoWrite;
			end
			default: begin
				// unknown bytes retire as one-byte instructions
				instrLength = 3'd1;
			end
		endcase
	end

	assign haveBytes = (byteCount >= instrLength);

	// stays up while the I/O instruction waits at the head
	assign dataRequest = haveBytes && isIo;
	assign retire = haveBytes && (!isIo || dataDone);

	// a jump empties the queue, so it flushes instead of consuming
	assign consume = retire && !isJump;
	assign consumeCount = instrLength;
	assign flush = retire && isJump;

	always_ff @(posedge CLOCK or posedge RESET) begin
		if (RESET) begin
			eax <= '0;
			ebx <= '0;
			instrPointer <= ResetVector;
		end else if (retire) begin
			if (isJump) begin
				instrPointer <= flushTarget;
			end else begin
				instrPointer <= instrPointer + 32'(instrLength);
			end
			case (opcode)
				core386Pkg::OpIncEax: begin
					eax <= eax + 1'b1;
				end
				core386Pkg::OpIncEbx: begin
					ebx <= ebx + 1'b1;
				end
				core386Pkg::OpMovEaxImm: begin
					eax <= window.immForm.imm;
				end
				core386Pkg::OpMovEbxImm: begin
					ebx <= window.immForm.imm;
				end
				core386Pkg::OpInAl: begin
					// the whole Datai word goes to EAX, not only AL
					eax <= readData;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/prefetchQueue.sv
`default_nettype none

module prefetchQueue #(
	parameter int QueueDepth = 16,
	parameter logic [31:0] ResetVector = 32'h000FFFF0
) (
	input wire CLOCK,
	input wire RESET,
	input wire codeDone,
	input wire [core386Pkg::DataWidth-1:0] codeData,
	input wire consume,
	input wire [2:0] consumeCount,
	input wire flush,
	input wire [31:0] flushTarget,
	output logic codeRequest,
	output logic [core386Pkg::WordAddrWidth-1:0] codeWordAddress,
	output core386Pkg::instrWindow_t window,
	output logic [2:0] byteCount
);

	localparam int PtrWidth = $clog2(QueueDepth);

	logic [7:0] queueMem [QueueDepth];
	// pointers carry one extra bit so a full queue differs from an empty one
	logic [PtrWidth:0] rdPtr;
	logic [PtrWidth:0] wrPtr;
	logic [PtrWidth:0] fillLevel;
	logic [PtrWidth:0] writeLength;
	// leading bytes of the next returned dword that lie below the target
	logic [1:0] skipCount;
	// set when a flush overtakes a fetch already requested
	logic staleFetch;
	logic acceptData;

	assign fillLevel = wrPtr - rdPtr;

	// bytes ready at the read pointer, saturated at 7
	// the longest instruction needs only 5
	assign byteCount = (fillLevel > 7) ? 3'd7 : fillLevel[2:0];

	assign acceptData = codeDone && !staleFetch && !flush;
	assign writeLength = (PtrWidth + 1)'(4 - skipCount);

	always_comb begin
		for (int k = 0; k < 5; k++) begin
			window[8*k +: 8] = queueMem[rdPtr[PtrWidth-1:0] + PtrWidth'(k)];
		end
	end

	always_ff @(posedge CLOCK) begin
		if (acceptData) begin
			for (int k = 0; k < 4; k++) begin
				// lane k lands at wrPtr once the skipped lanes are removed
				if (k >= skipCount) begin
					queueMem[wrPtr[PtrWidth-1:0] + PtrWidth'(k - skipCount)] <=
						codeData[8*k +: 8];
				end
			end
		end
	end

	always_ff @(posedge CLOCK or posedge RESET) begin
		if (RESET) begin
			rdPtr <= '0;
			wrPtr <= '0;
			codeWordAddress <= ResetVector[31:2];
			skipCount <= ResetVector[1:0];
			codeRequest <= 1'b0;
			staleFetch <= 1'b0;
		end else if (flush) begin
			rdPtr <= '0;
			wrPtr <= '0;
			codeWordAddress <= flushTarget[31:2];
			skipCount <= flushTarget[1:0];
			// a fetch still on the bus runs to its end and is thrown away
			staleFetch <= codeRequest && !codeDone;
			codeRequest <= codeRequest && !codeDone;
		end else begin
			if (consume) begin
				rdPtr <= rdPtr + (PtrWidth + 1)'(consumeCount);
			end
			if (codeDone) begin
				codeRequest <= 1'b0;
				staleFetch <= 1'b0;
				if (!staleFetch) begin
					wrPtr <= wrPtr + writeLength;
					skipCount <= 2'd0;
					codeWordAddress <= codeWordAddress + 1'b1;
				end
			end else if (!codeRequest && (fillLevel <= QueueDepth - 4)) begin
				// room for a whole dword
				codeRequest <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/programModel.svh
// image size in bytes; the closing jump is followed by padding so prefetch stays inside
localparam int MaxImage = 512;
localparam int PadBytes = 24;

logic [7:0] progMem [MaxImage];
int progLen = 0;
int finalJmpPos = 0;

// one entry per I/O cycle in program order
logic expWrite [$];
logic [7:0] expPort [$];
logic [31:0] expData [$];

task automatic putByte(input logic [7:0] value);
	progMem[progLen] = value;
	progLen++;
endtask

task automatic putWord(input logic [31:0] value);
	for (int k = 0; k < 4; k++) begin
		putByte(value[8*k +: 8]);
	end
endtask

task automatic buildProgram();
	logic [2:0] kind;
	logic [7:0] extra;
	int jmpPos;
	int skipLeft;
	jmpPos = 0;
	skipLeft = 0;
	for (int n = 0; n < NumInstr; n++) begin
		kind = 3'(takeBits(3));
		// no jump inside a stretch that another jump skips
		if (kind == 3'd5 && skipLeft > 0) begin
			kind = 3'd0;
		end
		case (kind)
			3'd0: putByte(core386Pkg::OpNop);
			3'd1: putByte(core386Pkg::OpIncEax);
			3'd2: putByte(core386Pkg::OpIncEbx);
			3'd3, 3'd4: begin
				putByte((kind == 3'd3) ? core386Pkg::OpMovEaxImm : core386Pkg::OpMovEbxImm);
				putWord(takeBits(32));
			end
			3'd5: begin
				putByte(core386Pkg::OpJmpShort);
				jmpPos = progLen;
				putByte(8'h00);
			end
			default: begin
				putByte((kind == 3'd6) ? core386Pkg::OpInAl : core386Pkg::OpOutAl);
				putByte(8'(takeBits(8)));
			end
		endcase
		if (takeBits(3) == 0) begin
			extra = 8'(takeBits(8));
			if (extra inside {core386Pkg::OpNop, core386Pkg::OpIncEax, core386Pkg::OpIncEbx,
				core386Pkg::OpMovEaxImm, core386Pkg::OpMovEbxImm, core386Pkg::OpJmpShort,
				core386Pkg::OpInAl, core386Pkg::OpOutAl}) begin
				extra = 8'h0F;
			end
			putByte(extra);
		end
		if (kind == 3'd5) begin
			// skip the next one to four instructions
			skipLeft = 1 + int'(takeBits(2));
		end else if (skipLeft > 0) begin
			skipLeft--;
			if (skipLeft == 0) begin
				progMem[jmpPos] = 8'(progLen - jmpPos - 1);
			end
		end
	end
	if (skipLeft > 0) begin
		progMem[jmpPos] = 8'(progLen - jmpPos - 1);
	end
	// keep the closing jump inside one dword
	if ((progLen + 2) % 4 == 3) begin
		putByte(core386Pkg::OpNop);
	end
	putByte(core386Pkg::OpOutAl);
	putByte(8'(takeBits(8)));
	finalJmpPos = progLen;
	putByte(core386Pkg::OpJmpShort);
	putByte(8'hFE);
	repeat (PadBytes) putByte(core386Pkg::OpNop);
	while (progLen % 4 != 0) begin
		putByte(core386Pkg::OpNop);
	end
endtask

// walks the program as executed and records every I/O cycle
task automatic buildExpected();
	int pc;
	logic [31:0] eax;
	logic [31:0] ebx;
	pc = 0;
	eax = '0;
	ebx = '0;
	while (pc != finalJmpPos) begin
		case (progMem[pc])
			core386Pkg::OpIncEax: eax = eax + 1;
			core386Pkg::OpIncEbx: ebx = ebx + 1;
			core386Pkg::OpMovEaxImm, core386Pkg::OpMovEbxImm: begin
				if (progMem[pc] == core386Pkg::OpMovEaxImm) begin
					eax = {progMem[pc + 4], progMem[pc + 3], progMem[pc + 2], progMem[pc + 1]};
				end else begin
					ebx = {progMem[pc + 4], progMem[pc + 3], progMem[pc + 2], progMem[pc + 1]};
				end
				pc += 4;
			end
			core386Pkg::OpJmpShort: begin
				pc = pc + 1 + int'($signed(progMem[pc + 1]));
			end
			core386Pkg::OpInAl, core386Pkg::OpOutAl: begin
				expWrite.push_back(progMem[pc] == core386Pkg::OpOutAl);
				expPort.push_back(progMem[pc + 1]);
				if (progMem[pc] == core386Pkg::OpInAl) begin
					// the word the responder will return, all of it lands in EAX
					eax = takeBits(32);
				end
				expData.push_back(eax);
				pc += 1;
			end
			default: begin
			end
		endcase
		pc += 1;
	end
endtask

// File: verif/core386Tb.sv
`default_nettype none

module core386Tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] ResetVector = 32'h000FFFF0;
	localparam logic [31:0] Seed = 32'h6fd4cb7a;
	localparam int NumInstr = 40;
	localparam int ResetCycles = 16;
	localparam int LoopFetchTarget = 6;

	logic CLOCK;
	logic RESET;
	logic [31:0] Datai;
	logic READY_n;
	logic HOLD;
	logic [3:0] BE_n;
	logic [29:0] Address;
	logic W_R_n;
	logic D_C_n;
	logic M_IO_n;
	logic ADS_n;
	logic [31:0] Datao;

	logic [31:0] lfsrState = Seed;
	int ioIndex = 0;
	int loopFetches = 0;
	int waitLeft = 0;
	logic waiting = 1'b0;
	logic readyPhase = 1'b0;
	logic finalIoDone = 1'b0;
	logic [31:0] replyData = '0;
	logic [29:0] jumpDword = '0;
	logic holdBlocked = 1'b0;
	logic monBusy = 1'b0;
	logic lastAds = 1'b1;

	core386Top #(
		.QueueDepth(16),
		.ResetVector(ResetVector)
	) u_dut (
		.CLOCK(CLOCK),
		.RESET(RESET),
		.Datai(Datai),
		.READY_n(READY_n),
		.HOLD(HOLD),
		.BE_n(BE_n),
		.Address(Address),
		.W_R_n(W_R_n),
		.D_C_n(D_C_n),
		.M_IO_n(M_IO_n),
		.ADS_n(ADS_n),
		.Datao(Datao)
	);

	// galois LFSR stepped once per bit handed out
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] result;
		result = '0;
		for (int i = 0; i < count; i++) begin
			result = {result[30:0], lfsrState[0]};
			lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
		end
		return result;
	endfunction

	`include "programModel.svh"

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stopWithFailure($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	// checks the cycle just started and picks the word to return
	task automatic startCycle();
		int offset;
		logic [7:0] port;
		if (M_IO_n === 1'b1) begin
			checkValue("BE_n", 32'(BE_n), 32'h0);
			checkValue("D_C_n", 32'(D_C_n), 32'h0);
			checkValue("W_R_n", 32'(W_R_n), 32'h0);
			offset = (int'(Address) - int'(ResetVector[31:2])) * 4;
			if (offset < 0 || offset + 4 > progLen) begin
				stopWithFailure($sformatf("code fetch outside the program at dword %h", Address));
			end
			replyData = {progMem[offset + 3], progMem[offset + 2], progMem[offset + 1],
				progMem[offset]};
			// one fetch may still go elsewhere before the closing loop settles
			if (finalIoDone) begin
				if (Address == jumpDword) begin
					loopFetches++;
				end else if (loopFetches > 0) begin
					checkValue("Address", 32'(Address), 32'(jumpDword));
				end
			end
		end else begin
			checkValue("M_IO_n", 32'(M_IO_n), 32'h0);
			if (ioIndex >= expWrite.size()) begin
				stopWithFailure("an I/O cycle appeared after the final OUT");
			end
			port = expPort[ioIndex];
			checkValue("D_C_n", 32'(D_C_n), 32'h1);
			checkValue("W_R_n", 32'(W_R_n), 32'(expWrite[ioIndex]));
			checkValue("Address", 32'(Address), 32'(port[7:2]));
			checkValue("BE_n", 32'(BE_n), 32'(4'b1111 ^ (4'b0001 << port[1:0])));
			if (expWrite[ioIndex]) begin
				checkValue("Datao", Datao, expData[ioIndex]);
			end
			replyData = expWrite[ioIndex] ? 32'h0 : expData[ioIndex];
			ioIndex++;
			finalIoDone = (ioIndex == expWrite.size());
		end
	endtask

	initial begin
		CLOCK = 1'b0;
		forever #2 CLOCK = ~CLOCK;
	end

	// bus responder with random wait states and HOLD while idle
	always @(posedge CLOCK) begin
		if (!RESET) begin
			if (ADS_n === 1'b0 && (waiting || readyPhase)) begin
				stopWithFailure("ADS_n went low while a bus cycle was still open");
			end
			if (readyPhase) begin
				READY_n <= 1'b1;
				readyPhase = 1'b0;
			end else begin
				if (ADS_n === 1'b0) begin
					startCycle();
					waitLeft = int'(takeBits(2));
					waiting = 1'b1;
				end
				if (waiting) begin
					if (waitLeft == 0) begin
						Datai <= replyData;
						READY_n <= 1'b0;
						waiting = 1'b0;
						readyPhase = 1'b1;
					end else begin
						waitLeft--;
					end
				end
			end
			if (HOLD) begin
				HOLD <= (takeBits(1) != 0);
			end else if (!waiting && !readyPhase) begin
				HOLD <= (takeBits(3) == 0);
			end
		end
	end

	// ADS_n rules against HOLD and back-to-back starts
	always @(posedge CLOCK) begin
		if (!RESET) begin
			if (holdBlocked) begin
				checkValue("ADS_n", 32'(ADS_n), 32'h1);
			end
			if (!lastAds && !ADS_n) begin
				stopWithFailure("ADS_n stayed low for two cycles in a row");
			end
			holdBlocked = HOLD && !monBusy && ADS_n;
			if (!ADS_n) begin
				monBusy = 1'b1;
			end else if (monBusy && !READY_n) begin
				monBusy = 1'b0;
			end
			lastAds = ADS_n;
		end
	end

	initial begin
		repeat (200 * NumInstr + ResetCycles) @(posedge CLOCK);
		stopWithFailure("timeout: the closing jump loop was never reached");
	end

	initial begin
		RESET = 1'b1;
		HOLD = 1'b0;
		READY_n = 1'b1;
		Datai = '0;
		buildProgram();
		buildExpected();
		jumpDword = 30'((ResetVector + 32'(finalJmpPos)) >> 2);
		repeat (ResetCycles) @(posedge CLOCK);
		checkValue("ADS_n", 32'(ADS_n), 32'h1);
		checkValue("BE_n", 32'(BE_n), 32'hF);
		checkValue("Address", 32'(Address), 32'h0);
		checkValue("W_R_n", 32'(W_R_n), 32'h0);
		checkValue("D_C_n", 32'(D_C_n), 32'h1);
		checkValue("M_IO_n", 32'(M_IO_n), 32'h0);
		checkValue("Datao", Datao, 32'h0);
		RESET <= 1'b0;
		while (loopFetches < LoopFetchTarget) begin
			@(posedge CLOCK);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verif
source/core386Pkg.sv
source/busInterfaceUnit.sv
source/prefetchQueue.sv
source/executionUnit.sv
source/core386Top.sv
verif/core386Tb.sv
